// File: common/coreTypesPkg.sv
package coreTypesPkg;

    // The ROB retires at most this many instructions per cycle
    localparam int commitWidth = 4;

    typedef logic [31:0] SqN;
    typedef logic [7:0] LoadSqN;
    typedef logic [7:0] StoreSqN;
    typedef logic [6:0] Tag;
    typedef logic [4:0] FetchId;
    typedef logic [7:0] BranchHistory;

    // Redirect request from any unit that can restart the frontend
    typedef struct packed {
        logic taken;
        logic flush;
        logic [31:0] dstPc;
        SqN sqN;
        LoadSqN loadSqN;
        StoreSqN storeSqN;
        FetchId fetchId;
        BranchHistory history;
    } BranchProv;

    // Sequence numbers wrap, so age is taken from the signed difference
    function automatic logic sqNYounger(SqN a, SqN b);
        logic signed [31:0] delta;
        delta = a - b;
        return delta > 0;
    endfunction

    // True when load number a is the same as or later than load number b
    function automatic logic loadSqNNotBefore(LoadSqN a, LoadSqN b);
        logic signed [7:0] delta;
        delta = a - b;
        return delta >= 0;
    endfunction

endpackage

// File: common/memOpsPkg.sv
package memOpsPkg;

    typedef enum logic [1:0] {
        aguNoException,
        aguMisaligned,
        aguAccessFault,
        aguPageFault
    } AguExc;

    // Uncached device region, accessed strictly in program order
    localparam logic [31:0] mmioBase = 32'hff00_0000;
    localparam logic [31:0] mmioTop = 32'hff0f_ffff;

    // Memory micro-op as it leaves address generation
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        logic doNotCommit;
        coreTypesPkg::SqN sqN;
        coreTypesPkg::LoadSqN loadSqN;
        coreTypesPkg::StoreSqN storeSqN;
        coreTypesPkg::Tag tagDst;
        logic [31:0] pc;
        logic compressed;
        coreTypesPkg::FetchId fetchId;
        coreTypesPkg::BranchHistory history;
        AguExc exception;
    } AguUop;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        logic signExtend;
        logic doNotCommit;
        coreTypesPkg::SqN sqN;
        coreTypesPkg::LoadSqN loadSqN;
        coreTypesPkg::Tag tagDst;
        logic isMmio;
        AguExc exception;
    } LdUop;

    typedef struct packed {
        logic valid;
        logic fail;
        coreTypesPkg::LoadSqN loadSqN;
    } LdAck;

    function automatic logic isMmio(logic [31:0] addr);
        return addr >= mmioBase && addr <= mmioTop;
    endfunction

    // Byte lanes touched inside the 32-bit word; sizes 2 and 3 are full words
    function automatic logic [3:0] byteMask(logic [1:0] offset, logic [1:0] size);
        logic [3:0] mask;
        case (size)
            2'd0: mask = 4'b0001 << offset;
            2'd1: mask = offset[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    function automatic logic bytesOverlap(logic [31:0] stAddr, logic [1:0] stSize,
                                          logic [31:0] ldAddr, logic [1:0] ldSize);
        logic sameWord;
        sameWord = stAddr[31:2] == ldAddr[31:2];
        return sameWord && |(byteMask(stAddr[1:0], stSize) & byteMask(ldAddr[1:0], ldSize));
    endfunction

endpackage

// File: loadBuffer/lateIssueSelect.sv
`timescale 1ns/1ps

module lateIssueSelect #(
    parameter int numEntries = 8
) (
    input logic [numEntries-1:0] entryValid,
    input logic [numEntries-1:0] entryIssued,
    input logic [numEntries-1:0] entryNonSpec,
    input logic [$clog2(numEntries)-1:0] deqIndex,
    input coreTypesPkg::SqN headSqN,
    input coreTypesPkg::SqN commitSqN,
    input logic sqDone,
    output logic [$clog2(numEntries)-1:0] issueIdx,
    output logic issueValid
);
    localparam int idxBits = $clog2(numEntries);

    logic [numEntries-1:0] candidates;
    logic headReady;

    // Regular loads may go in any order once they are waiting
    assign candidates = entryValid & ~entryIssued & ~entryNonSpec;

    // MMIO loads wait until they are the oldest thing in flight and all stores drained
    assign headReady = entryValid[deqIndex] && !entryIssued[deqIndex] &&
                       (!entryNonSpec[deqIndex] || (commitSqN == headSqN && sqDone));

    always_comb begin
        logic [idxBits-1:0] idx;
        issueIdx = deqIndex;
        issueValid = 1'b0;

        // Rotate from the head so older loads are preferred
        for (int i = 0; i < numEntries; i++) begin
            idx = deqIndex + i[idxBits-1:0];
            if (candidates[idx] && !issueValid) begin
                issueValid = 1'b1;
                issueIdx = idx;
            end
        end

        // The head is in order by definition and always wins
        if (headReady) begin
            issueValid = 1'b1;
            issueIdx = deqIndex;
        end
    end

endmodule

// File: loadBuffer/loadBuffer.sv
`timescale 1ns/1ps

module loadBuffer #(
    parameter int numEntries = 8
) (
    input logic clk,
    input logic rst,
    input coreTypesPkg::SqN commitSqN,
    input logic sqDone,
    input memOpsPkg::AguUop ldIn,
    input memOpsPkg::AguUop stIn,
    input memOpsPkg::LdAck ldAck,
    input logic lateTaken,
    input coreTypesPkg::BranchProv branchIn,
    output memOpsPkg::LdUop earlyLd,
    output memOpsPkg::LdUop lateLd,
    output coreTypesPkg::BranchProv branchOut,
    output coreTypesPkg::LoadSqN maxLoadSqN
);
    import coreTypesPkg::*;
    import memOpsPkg::*;

    localparam int idxBits = $clog2(numEntries);
    localparam int highBits = $bits(LoadSqN) - idxBits;

    // Low bits of the load number are the slot index, only the rest is stored
    typedef struct packed {
        SqN sqN;
        Tag tagDst;
        logic [highBits-1:0] highLdSqN;
        logic [1:0] size;
        logic [31:0] addr;
        logic signExtend;
        logic doNotCommit;
        AguExc exception;
        logic nonSpec;
        logic issued;
        logic valid;
    } LbEntry;

    LbEntry entries [numEntries];

    LoadSqN baseIndex;
    LoadSqN nextBase;
    logic [idxBits-1:0] deqIndex;
    logic [idxBits-1:0] insIdx;
    SqN headSqN;

    logic ldClean;
    logic nonSpecIn;
    logic sameCycleConflict;
    logic delayIn;
    logic insertValid;
    logic storeValid;
    logic storeConflict;

    logic [numEntries-1:0] entryValid;
    logic [numEntries-1:0] entryIssued;
    logic [numEntries-1:0] entryNonSpec;
    logic [idxBits-1:0] issueIdx;
    logic issueValid;
    logic issueLate;
    logic doRetire;
    logic [numEntries-1:0] retireVec;
    logic [2:0] retireCount;

    assign deqIndex = baseIndex[idxBits-1:0];
    assign insIdx = ldIn.loadSqN[idxBits-1:0];
    assign headSqN = entries[deqIndex].sqN;

    assign ldClean = ldIn.valid && ldIn.exception == aguNoException;
    assign nonSpecIn = ldClean && isMmio(ldIn.addr);

    // A store in the same cycle has not reached the store queue yet, so forwarding
    // from it is impossible and the load has to wait in the buffer
    assign sameCycleConflict = ldClean && stIn.valid &&
                               loadSqNNotBefore(ldIn.loadSqN, stIn.loadSqN) &&
                               bytesOverlap(stIn.addr, stIn.size, ldIn.addr, ldIn.size);
    assign delayIn = nonSpecIn || sameCycleConflict;

    assign insertValid = ldIn.valid && !(branchIn.taken && sqNYounger(ldIn.sqN, branchIn.sqN));
    assign storeValid = stIn.valid && !(branchIn.taken && sqNYounger(stIn.sqN, branchIn.sqN));

    always_comb begin
        earlyLd = '0;
        if (!delayIn) begin
            earlyLd.addr = ldIn.addr;
            earlyLd.size = ldIn.size;
            earlyLd.signExtend = ldIn.signExtend;
            earlyLd.doNotCommit = ldIn.doNotCommit;
            earlyLd.sqN = ldIn.sqN;
            earlyLd.loadSqN = ldIn.loadSqN;
            earlyLd.tagDst = ldIn.tagDst;
            earlyLd.isMmio = isMmio(ldIn.addr);
            earlyLd.exception = ldIn.exception;
            earlyLd.valid = ldIn.valid;
        end
    end

    // Any younger load that already read memory got stale data from this store.
    // Order of the scan is irrelevant since the redirect restarts after the store
    always_comb begin
        LoadSqN entryLdSqN;
        storeConflict = 1'b0;
        for (int i = 0; i < numEntries; i++) begin
            entryLdSqN = {entries[i].highLdSqN, i[idxBits-1:0]};
            if (entries[i].valid && entries[i].issued &&
                loadSqNNotBefore(entryLdSqN, stIn.loadSqN) &&
                bytesOverlap(stIn.addr, stIn.size, entries[i].addr, entries[i].size)) begin
                storeConflict = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < numEntries; i++) begin
            entryValid[i] = entries[i].valid;
            entryIssued[i] = entries[i].issued;
            entryNonSpec[i] = entries[i].nonSpec;
        end
    end

    lateIssueSelect #(
        .numEntries(numEntries)
    ) issueSel (
        .entryValid(entryValid),
        .entryIssued(entryIssued),
        .entryNonSpec(entryNonSpec),
        .deqIndex(deqIndex),
        .headSqN(headSqN),
        .commitSqN(commitSqN),
        .sqDone(sqDone),
        .issueIdx(issueIdx),
        .issueValid(issueValid)
    );

    assign issueLate = !branchIn.taken && (!lateLd.valid || lateTaken) && issueValid;
    assign doRetire = !branchIn.taken && !issueLate;

    // Retirement must keep up with the ROB, so up to commitWidth heads go at once
    always_comb begin
        logic run;
        logic [idxBits-1:0] idx;
        run = 1'b1;
        retireVec = '0;
        retireCount = '0;
        for (int i = 0; i < commitWidth; i++) begin
            idx = deqIndex + i[idxBits-1:0];
            if (run && entries[idx].valid && entries[idx].issued &&
                sqNYounger(commitSqN, entries[idx].sqN)) begin
                retireVec[idx] = 1'b1;
                retireCount = retireCount + 3'd1;
            end else begin
                run = 1'b0;
            end
        end
    end

    always_comb begin
        nextBase = baseIndex;
        if (branchIn.taken) begin
            if (branchIn.flush) begin
                nextBase = branchIn.loadSqN;
            end
        end else if (doRetire) begin
            nextBase = baseIndex + LoadSqN'(retireCount);
        end
    end

    always_ff @(posedge clk) begin
        branchOut.taken <= 1'b0;
        if (rst) begin
            for (int i = 0; i < numEntries; i++) begin
                entries[i].valid <= 1'b0;
            end
            baseIndex <= '0;
            maxLoadSqN <= LoadSqN'(numEntries - 1);
            lateLd.valid <= 1'b0;
        end else begin
            if (lateTaken) begin
                lateLd.valid <= 1'b0;
            end

            // A refused load goes back to waiting and is picked up as a late load
            if (ldAck.valid && ldAck.fail) begin
                entries[ldAck.loadSqN[idxBits-1:0]].issued <= 1'b0;
            end

            if (branchIn.taken) begin
                for (int i = 0; i < numEntries; i++) begin
                    if (sqNYounger(entries[i].sqN, branchIn.sqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
                if (lateLd.valid && sqNYounger(lateLd.sqN, branchIn.sqN)) begin
                    lateLd.valid <= 1'b0;
                end
            end else if (issueLate) begin
                entries[issueIdx].issued <= 1'b1;
                lateLd.addr <= entries[issueIdx].addr;
                lateLd.size <= entries[issueIdx].size;
                lateLd.signExtend <= entries[issueIdx].signExtend;
                lateLd.doNotCommit <= entries[issueIdx].doNotCommit;
                lateLd.sqN <= entries[issueIdx].sqN;
                lateLd.loadSqN <= {entries[issueIdx].highLdSqN, issueIdx};
                lateLd.tagDst <= entries[issueIdx].tagDst;
                lateLd.isMmio <= isMmio(entries[issueIdx].addr);
                lateLd.exception <= entries[issueIdx].exception;
                lateLd.valid <= 1'b1;
            end else begin
                for (int i = 0; i < numEntries; i++) begin
                    if (retireVec[i]) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end

            if (insertValid) begin
                entries[insIdx].sqN <= ldIn.sqN;
                entries[insIdx].tagDst <= ldIn.tagDst;
                entries[insIdx].highLdSqN <= ldIn.loadSqN[$bits(LoadSqN)-1:idxBits];
                entries[insIdx].size <= ldIn.size;
                entries[insIdx].addr <= ldIn.addr;
                entries[insIdx].signExtend <= ldIn.signExtend;
                entries[insIdx].doNotCommit <= ldIn.doNotCommit;
                entries[insIdx].exception <= ldIn.exception;
                entries[insIdx].nonSpec <= nonSpecIn;
                entries[insIdx].issued <= !delayIn;
                entries[insIdx].valid <= 1'b1;
            end

            // Restart right after the store rather than at the offending load
            if (storeValid && storeConflict) begin
                branchOut.taken <= 1'b1;
                branchOut.flush <= 1'b0;
                branchOut.dstPc <= stIn.pc + (stIn.compressed ? 32'd2 : 32'd4);
                branchOut.sqN <= stIn.sqN;
                branchOut.loadSqN <= stIn.loadSqN;
                branchOut.storeSqN <= stIn.storeSqN;
                branchOut.fetchId <= stIn.fetchId;
                branchOut.history <= stIn.history;
            end

            baseIndex <= nextBase;
            maxLoadSqN <= nextBase + LoadSqN'(numEntries - 1);
        end
    end

    // Dispatch stalls on maxLoadSqN, so a live slot is never overwritten
    assert property (@(posedge clk) disable iff (rst) insertValid |-> !entries[insIdx].valid)
        else $error("load inserted over a live buffer entry");

    assert property (@(posedge clk) disable iff (rst)
        branchOut.taken |=> !(branchOut.taken && branchOut.sqN == $past(branchOut.sqN)))
        else $error("same store redirected twice in a row");

endmodule

// File: rtl/loadPort.sv
`timescale 1ns/1ps

module loadPort (
    input logic clk,
    input logic rst,
    input logic stall,
    input memOpsPkg::LdUop earlyLd,
    input memOpsPkg::LdUop lateLd,
    output memOpsPkg::LdUop memReq,
    output memOpsPkg::LdAck ldAck,
    output logic lateTaken
);
    import memOpsPkg::*;

    LdUop chosen;
    logic earlyRefused;

    // The late load sits in the buffer's register until the memory side is free
    assign lateTaken = lateLd.valid && !stall;

    // An early load cannot wait, so it loses to a stall and to any late load
    assign earlyRefused = earlyLd.valid && (stall || lateLd.valid);

    always_comb begin
        chosen = earlyLd;
        if (lateLd.valid) begin
            chosen = lateLd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memReq.valid <= 1'b0;
            ldAck.valid <= 1'b0;
        end else begin
            // Memory keeps looking at the same request until the stall clears
            if (!stall) begin
                memReq <= chosen;
            end

            // Refusals take the ack slot, otherwise the accepted load is acked
            ldAck.valid <= earlyLd.valid || lateTaken;
            ldAck.fail <= earlyRefused;
            ldAck.loadSqN <= earlyRefused ? earlyLd.loadSqN : chosen.loadSqN;
        end
    end

endmodule

// File: rtl/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit #(
    parameter int numEntries = 8
) (
    input logic clk,
    input logic rst,
    input memOpsPkg::AguUop ldIn,
    input memOpsPkg::AguUop stIn,
    input coreTypesPkg::SqN commitSqN,
    input logic sqDone,
    input coreTypesPkg::BranchProv branchIn,
    input logic stall,
    output memOpsPkg::LdUop memReq,
    output coreTypesPkg::BranchProv branchOut,
    output coreTypesPkg::LoadSqN maxLoadSqN
);
    import memOpsPkg::*;

    LdUop earlyLd;
    LdUop lateLd;
    LdAck ldAck;
    logic lateTaken;

    loadBuffer #(
        .numEntries(numEntries)
    ) buffer (
        .clk(clk),
        .rst(rst),
        .commitSqN(commitSqN),
        .sqDone(sqDone),
        .ldIn(ldIn),
        .stIn(stIn),
        .ldAck(ldAck),
        .lateTaken(lateTaken),
        .branchIn(branchIn),
        .earlyLd(earlyLd),
        .lateLd(lateLd),
        .branchOut(branchOut),
        .maxLoadSqN(maxLoadSqN)
    );

    // Single memory port shared by both load paths
    loadPort port (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .earlyLd(earlyLd),
        .lateLd(lateLd),
        .memReq(memReq),
        .ldAck(ldAck),
        .lateTaken(lateTaken)
    );

endmodule

// File: tests/lsuTestTasks.svh
// Inputs change and outputs are read 2 ns after the rising edge
task automatic nextCycle();
    @(posedge clk);
    #2;
endtask

// Cacheable address that is 16-byte aligned so tests can pick distinct words
function automatic logic [31:0] plainAddr();
    return $urandom & 32'h7fff_fff0;
endfunction

task automatic buildLoad(output AguUop uop, input logic [31:0] addr, input logic [1:0] size);
    uop = '0;
    uop.valid = 1'b1;
    uop.addr = addr;
    uop.size = size;
    uop.sqN = nextSqN;
    uop.loadSqN = nextLdSqN;
    uop.tagDst = Tag'($urandom);
    uop.pc = $urandom & 32'hffff_fffe;
    uop.exception = aguNoException;
    nextSqN++;
    nextLdSqN++;
endtask

// A store carries the number of the next load, so later loads count as younger
task automatic buildStore(output AguUop uop, input logic [31:0] addr, input logic [1:0] size,
                          input logic compressed);
    uop = '0;
    uop.valid = 1'b1;
    uop.addr = addr;
    uop.size = size;
    uop.sqN = nextSqN;
    uop.loadSqN = nextLdSqN;
    uop.pc = $urandom & 32'hffff_fffe;
    uop.compressed = compressed;
    uop.exception = aguNoException;
    nextSqN++;
endtask

task automatic sendLoad(input AguUop ld);
    ldIn = ld;
    nextCycle();
    ldIn = '0;
endtask

task automatic sendPair(input AguUop st, input AguUop ld);
    stIn = st;
    ldIn = ld;
    nextCycle();
    stIn = '0;
    ldIn = '0;
endtask

task automatic verifyRequest(input AguUop ld, input logic mmio);
    checkValue("memReq.valid", 32'(memReq.valid), 32'd1);
    checkValue("memReq.addr", memReq.addr, ld.addr);
    checkValue("memReq.size", 32'(memReq.size), 32'(ld.size));
    checkValue("memReq.tagDst", 32'(memReq.tagDst), 32'(ld.tagDst));
    checkValue("memReq.loadSqN", 32'(memReq.loadSqN), 32'(ld.loadSqN));
    checkValue("memReq.isMmio", 32'(memReq.isMmio), 32'(mmio));
endtask

task automatic countRequests(input LoadSqN ldSqN, input int cycles, output int hits);
    hits = 0;
    for (int i = 0; i < cycles; i++) begin
        if (memReq.valid && memReq.loadSqN == ldSqN) begin
            hits++;
        end
        nextCycle();
    end
endtask

task automatic waitForRequest(input LoadSqN ldSqN, input int maxCycles);
    int waited;
    waited = 0;
    while (!(memReq.valid && memReq.loadSqN == ldSqN)) begin
        if (waited == maxCycles) begin
            $display("Finished with errors");
            $fatal(1, "Load %0d never reached the memory request port", ldSqN);
        end else begin
            waited++;
            nextCycle();
        end
    end
endtask

task automatic expectNoRepeat(input LoadSqN ldSqN);
    int hits;
    nextCycle();
    countRequests(ldSqN, 6, hits);
    checkValue("memReq repeat count", 32'(hits), 32'd0);
endtask

// The restart address is the store's pc advanced by its instruction length
task automatic expectRedirect(input AguUop st, input logic hit, input logic [31:0] pcStep);
    stIn = st;
    nextCycle();
    stIn = '0;
    checkValue("branchOut.taken", 32'(branchOut.taken), 32'(hit));
    if (hit) begin
        checkValue("branchOut.sqN", branchOut.sqN, st.sqN);
        checkValue("branchOut.dstPc", branchOut.dstPc, st.pc + pcStep);
    end
    nextCycle();
    checkValue("branchOut.taken", 32'(branchOut.taken), 32'd0);
endtask

// Commit everything handed out so far and wait until the buffer is empty
task automatic drainBuffer();
    LoadSqN expectedMax;
    int waited;
    expectedMax = nextLdSqN + LoadSqN'(numEntries - 1);
    commitSqN = nextSqN;
    sqDone = 1'b1;
    waited = 0;
    while (maxLoadSqN != expectedMax) begin
        if (waited == 20) begin
            $display("Finished with errors");
            $fatal(1, "Load buffer did not retire all committed loads");
        end else begin
            waited++;
            nextCycle();
        end
    end
endtask

task automatic earlyPathTest();
    AguUop ld;
    buildLoad(ld, plainAddr() + 32'd4, 2'd2);
    sendLoad(ld);
    verifyRequest(ld, 1'b0);
    expectNoRepeat(ld.loadSqN);
    drainBuffer();
endtask

task automatic mmioOrderTest();
    AguUop ld;
    int hits;
    buildLoad(ld, mmioBase + ($urandom & 32'h000f_fffc), 2'd2);
    commitSqN = ld.sqN - 32'd1;
    sqDone = 1'b1;
    sendLoad(ld);
    countRequests(ld.loadSqN, 8, hits);
    checkValue("MMIO requests before commit", 32'(hits), 32'd0);
    commitSqN = ld.sqN;
    sqDone = 1'b0;
    countRequests(ld.loadSqN, 8, hits);
    checkValue("MMIO requests before sqDone", 32'(hits), 32'd0);
    sqDone = 1'b1;
    waitForRequest(ld.loadSqN, 10);
    verifyRequest(ld, 1'b1);
    expectNoRepeat(ld.loadSqN);
    drainBuffer();
endtask

task automatic storeOverlapTest();
    AguUop st;
    AguUop ld;
    logic [31:0] base;
    base = plainAddr();
    buildStore(st, base, 2'd2, 1'b0);
    buildLoad(ld, base + 32'd1, 2'd0);
    sendPair(st, ld);
    checkValue("memReq.valid", 32'(memReq.valid), 32'd0);
    checkValue("branchOut.taken", 32'(branchOut.taken), 32'd0);
    waitForRequest(ld.loadSqN, 10);
    verifyRequest(ld, 1'b0);
    expectNoRepeat(ld.loadSqN);

    // Store byte 0 and load bytes 2 and 3 share the word but no lane
    buildStore(st, base + 32'd8, 2'd0, 1'b0);
    buildLoad(ld, base + 32'd10, 2'd1);
    sendPair(st, ld);
    verifyRequest(ld, 1'b0);
    checkValue("branchOut.taken", 32'(branchOut.taken), 32'd0);
    drainBuffer();
endtask

task automatic orderViolationTest();
    AguUop st;
    AguUop ld;
    logic [31:0] base;
    base = plainAddr();
    buildStore(st, base + 32'd2, 2'd1, 1'b0);
    buildLoad(ld, base, 2'd2);
    sendLoad(ld);
    verifyRequest(ld, 1'b0);
    expectRedirect(st, 1'b1, 32'd4);

    buildStore(st, base + 32'd4, 2'd0, 1'b1);
    buildLoad(ld, base + 32'd4, 2'd1);
    sendLoad(ld);
    expectRedirect(st, 1'b1, 32'd2);

    buildStore(st, base + 32'd11, 2'd0, 1'b0);
    buildLoad(ld, base + 32'd8, 2'd0);
    sendLoad(ld);
    expectRedirect(st, 1'b0, 32'd4);
    drainBuffer();
endtask

task automatic squashTest();
    AguUop ld;
    LoadSqN expectedMax;
    int hits;
    buildLoad(ld, mmioBase + 32'h0000_0100, 2'd2);
    commitSqN = ld.sqN - 32'd1;
    sqDone = 1'b1;
    sendLoad(ld);
    branchIn = '0;
    branchIn.taken = 1'b1;
    branchIn.flush = 1'b1;
    branchIn.sqN = ld.sqN - 32'd1;
    branchIn.loadSqN = ld.loadSqN;
    nextCycle();
    branchIn = '0;
    expectedMax = ld.loadSqN + LoadSqN'(numEntries - 1);
    checkValue("maxLoadSqN", 32'(maxLoadSqN), 32'(expectedMax));

    // The squashed load number is handed out again
    nextLdSqN = ld.loadSqN;
    commitSqN = ld.sqN;
    countRequests(ld.loadSqN, 20, hits);
    checkValue("squashed load requests", 32'(hits), 32'd0);
    drainBuffer();
endtask

task automatic retireTest();
    AguUop ld;
    LoadSqN base;
    LoadSqN expectedMax;
    int remaining;
    int step;
    base = nextLdSqN;
    for (int i = 0; i < 6; i++) begin
        buildLoad(ld, plainAddr(), 2'd2);
        sendLoad(ld);
    end
    expectedMax = base + LoadSqN'(numEntries - 1);
    checkValue("maxLoadSqN", 32'(maxLoadSqN), 32'(expectedMax));

    remaining = 6;
    commitSqN = nextSqN;
    while (remaining > 0) begin
        step = (remaining > 4) ? 4 : remaining;
        remaining -= step;
        base += LoadSqN'(step);
        expectedMax = base + LoadSqN'(numEntries - 1);
        nextCycle();
        checkValue("maxLoadSqN", 32'(maxLoadSqN), 32'(expectedMax));
    end
endtask

task automatic backPressureTest();
    AguUop ld;
    LdUop held;
    buildLoad(ld, plainAddr() + 32'd12, 2'd2);
    checkValue("memReq.valid", 32'(memReq.valid), 32'd0);
    held = memReq;
    stall = 1'b1;
    sendLoad(ld);
    for (int i = 0; i < 8; i++) begin
        checkValue("memReq.valid", 32'(memReq.valid), 32'(held.valid));
        checkValue("memReq.addr", memReq.addr, held.addr);
        checkValue("memReq.loadSqN", 32'(memReq.loadSqN), 32'(held.loadSqN));
        nextCycle();
    end
    stall = 1'b0;
    waitForRequest(ld.loadSqN, 10);
    verifyRequest(ld, 1'b0);
    expectNoRepeat(ld.loadSqN);
    drainBuffer();
endtask

// File: tests/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;
    import coreTypesPkg::*;
    import memOpsPkg::*;

    localparam int numEntries = 8;
    localparam int clkPeriod = 20;
    localparam int numTests = 7;
    localparam int cyclesPerTest = 200;

    logic clk;
    logic rst;
    AguUop ldIn;
    AguUop stIn;
    SqN commitSqN;
    logic sqDone;
    BranchProv branchIn;
    logic stall;
    LdUop memReq;
    BranchProv branchOut;
    LoadSqN maxLoadSqN;

    // Next free sequence and load numbers, handed out in program order
    SqN nextSqN;
    LoadSqN nextLdSqN;

    loadStoreUnit #(
        .numEntries(numEntries)
    ) dut (
        .clk(clk),
        .rst(rst),
        .ldIn(ldIn),
        .stIn(stIn),
        .commitSqN(commitSqN),
        .sqDone(sqDone),
        .branchIn(branchIn),
        .stall(stall),
        .memReq(memReq),
        .branchOut(branchOut),
        .maxLoadSqN(maxLoadSqN)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Each directed test gets a fixed budget of cycles
    initial begin
        #(numTests * cyclesPerTest * clkPeriod);
        $display("Finished with errors");
        $fatal(1, "Watchdog expired before the test sequence completed");
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    `include "lsuTestTasks.svh"

    initial begin
        void'($urandom(32'hfd3c_2a70));
        nextSqN = 32'd1;
        nextLdSqN = '0;
        rst = 1'b1;
        ldIn = '0;
        stIn = '0;
        commitSqN = '0;
        sqDone = 1'b0;
        branchIn = '0;
        stall = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        checkValue("memReq.valid", 32'(memReq.valid), 32'd0);
        checkValue("branchOut.taken", 32'(branchOut.taken), 32'd0);
        checkValue("maxLoadSqN", 32'(maxLoadSqN), 32'(numEntries - 1));

        earlyPathTest();
        mmioOrderTest();
        storeOverlapTest();
        orderViolationTest();
        squashTest();
        retireTest();
        backPressureTest();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: loadStoreUnit.f
+incdir+tests
common/coreTypesPkg.sv
common/memOpsPkg.sv
loadBuffer/lateIssueSelect.sv
loadBuffer/loadBuffer.sv
rtl/loadPort.sv
rtl/loadStoreUnit.sv
tests/lsuTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP = lsuTb
FILELIST = loadStoreUnit.f
OBJDIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
